//--- Bender.yml
package:
  name: rv_core

sources:
  - verilog/rvPkg.sv
  - verilog/ControlUnit.sv
  - verilog/ImmGen.sv
  - verilog/Alu.sv
  - verilog/RegFile.sv
  - verilog/ProgramCounter.sv
  - verilog/LoadStoreUnit.sv
  - verilog/RvCore.sv
  - target: simulation
    files:
      - verif/tbRvCore.sv

//--- project.f
verilog/rvPkg.sv
verilog/ControlUnit.sv
verilog/ImmGen.sv
verilog/Alu.sv
verilog/RegFile.sv
verilog/ProgramCounter.sv
verilog/LoadStoreUnit.sv
verilog/RvCore.sv
verif/tbRvCore.sv

//--- verif/coreTests.txt
# P addr instr, D addr word, S addr data sel (program order), H final pc
# all values hex
P 00000000 20000513
P 00000004 ff900093
P 00000008 00500113
P 0000000c 002081b3
P 00000010 00352023
P 00000014 40208233
P 00000018 00452223
P 0000001c 4020d2b3
P 00000020 0020d333
P 00000024 00552423
P 00000028 00652623
P 0000002c 0020a1b3
P 00000030 0020b233
P 00000034 002112b3
P 00000038 0020c333
P 0000003c 00352823
P 00000040 00452a23
P 00000044 00552c23
P 00000048 00652e23
P 0000004c 0020e1b3
P 00000050 0020f233
P 00000054 0f00c293
P 00000058 4010d313
P 0000005c 02352023
P 00000060 02452223
P 00000064 02552423
P 00000068 02652623
P 0000006c 123451b7
P 00000070 00001217
P 00000074 ffa0a293
P 00000078 07f0f313
P 0000007c 02352823
P 00000080 02452a23
P 00000084 02552c23
P 00000088 02652e23
P 0000008c 30000593
P 00000090 00158183
P 00000094 0035c203
P 00000098 00259283
P 0000009c 0005d303
P 000000a0 0005a383
P 000000a4 00358603
P 000000a8 04352023
P 000000ac 04452223
P 000000b0 04552423
P 000000b4 04652623
P 000000b8 04752823
P 000000bc 04c52a23
P 000000c0 04750c23
P 000000c4 04750ca3
P 000000c8 04750d23
P 000000cc 04750da3
P 000000d0 04751e23
P 000000d4 04751f23
P 000000d8 00208463
P 000000dc 00210463
P 000000e0 08052023
P 000000e4 00211463
P 000000e8 00209463
P 000000ec 08052023
P 000000f0 00114463
P 000000f4 0020c463
P 000000f8 08052023
P 000000fc 0020d463
P 00000100 00115463
P 00000104 08052023
P 00000108 0020e463
P 0000010c 00116463
P 00000110 08052023
P 00000114 00117463
P 00000118 0020f463
P 0000011c 08052023
P 00000120 00c001ef
P 00000124 08052023
P 00000128 08052023
P 0000012c 06352023
P 00000130 13b00213
P 00000134 005202e7
P 00000138 08052023
P 0000013c 08052023
P 00000140 06552223
P 00000144 00000073
D 00000300 8a7b6c5d
S 00000200 fffffffe f
S 00000204 fffffff4 f
S 00000208 ffffffff f
S 0000020c 07ffffff f
S 00000210 00000001 f
S 00000214 00000000 f
S 00000218 000000a0 f
S 0000021c fffffffc f
S 00000220 fffffffd f
S 00000224 00000001 f
S 00000228 ffffff09 f
S 0000022c fffffffc f
S 00000230 12345000 f
S 00000234 00001070 f
S 00000238 00000001 f
S 0000023c 00000079 f
S 00000240 0000006c f
S 00000244 0000008a f
S 00000248 ffff8a7b f
S 0000024c 00006c5d f
S 00000250 8a7b6c5d f
S 00000254 ffffff8a f
S 00000258 5d5d5d5d 1
S 00000258 5d5d5d5d 2
S 00000258 5d5d5d5d 4
S 00000258 5d5d5d5d 8
S 0000025c 6c5d6c5d 3
S 0000025c 6c5d6c5d c
S 00000260 00000124 f
S 00000264 00000138 f
H 00000144

//--- verif/tbRvCore.sv
`timescale 1ns/100ps

module tbRvCore;

    localparam int xlen = rvPkg::xlen;
    localparam int selW = rvPkg::selW;
    localparam int memWords = 256;
    localparam int haltLimit = 5000;

    logic clk;
    logic rstN;
    logic [xlen-1:0] instrAddr;
    logic [xlen-1:0] instrData;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [xlen-1:0] wbAdr;
    logic [xlen-1:0] wbDatW;
    logic [selW-1:0] wbSel;
    logic [xlen-1:0] wbDatR;
    logic wbAck;
    logic halted;

    logic [xlen-1:0] imem [memWords];
    logic [xlen-1:0] dmem [memWords];

    // expected stores in program order
    logic [xlen-1:0] expAdrQ [$];
    logic [xlen-1:0] expDatQ [$];
    logic [selW-1:0] expSelQ [$];
    logic [xlen-1:0] expPc;

    integer seed;
    integer waitLeft;
    logic inCycle;
    logic [xlen-1:0] capAdr;
    logic [xlen-1:0] capDat;
    logic [selW-1:0] capSel;
    logic capWe;

    RvCore u_dut (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instrData(instrData),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbSel(wbSel), .wbDatR(wbDatR), .wbAck(wbAck), .halted(halted)
    );

    always #10 clk = ~clk;

    // instruction port answers in the same cycle
    assign instrData = imem[instrAddr[9:2]];

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
        string msg;
        if (got !== exp) begin
            msg = $sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            abortRun(msg);
        end
    endtask

    task automatic checkSel(input string name, input logic [selW-1:0] got,
                            input logic [selW-1:0] exp);
        string msg;
        if (got !== exp) begin
            msg = $sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            abortRun(msg);
        end
    endtask

    task automatic loadTests();
        integer fd;
        integer n;
        string kind;
        string rest;
        logic [xlen-1:0] a;
        logic [xlen-1:0] d;
        logic [selW-1:0] s;
        fd = $fopen("verif/coreTests.txt", "r");
        if (fd == 0) begin
            abortRun("could not open the test data file verif/coreTests.txt");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1) begin
                break;
            end
            if (kind == "#") begin
                n = $fgets(rest, fd);
            end else if (kind == "P") begin
                n = $fscanf(fd, "%h %h", a, d);
                imem[a[9:2]] = d;
            end else if (kind == "D") begin
                n = $fscanf(fd, "%h %h", a, d);
                dmem[a[9:2]] = d;
            end else if (kind == "S") begin
                n = $fscanf(fd, "%h %h %h", a, d, s);
                expAdrQ.push_back(a);
                expDatQ.push_back(d);
                expSelQ.push_back(s);
            end else if (kind == "H") begin
                n = $fscanf(fd, "%h", expPc);
            end else begin
                abortRun($sformatf("unknown record kind %s in the test data file", kind));
            end
        end
        $fclose(fd);
    endtask

    // a finished store must be the next one the program expects
    task automatic matchStore();
        if (expAdrQ.size() == 0) begin
            abortRun($sformatf("unexpected store to %h at %0t", capAdr, $time));
        end
        checkWord("wbAdr", capAdr, expAdrQ.pop_front());
        checkWord("wbDatW", capDat, expDatQ.pop_front());
        checkSel("wbSel", capSel, expSelQ.pop_front());
    endtask

    // wishbone slave with random wait states
    always @(posedge clk) begin
        #2;
        if (rstN) begin
            if (wbAck) begin
                wbAck = 1'b0;
                inCycle = 1'b0;
            end
            if (halted && wbCyc) begin
                abortRun("a bus cycle started after the core halted");
            end
            if (wbStb && !wbCyc) begin
                abortRun("strobe is high without cycle");
            end
            if (wbCyc && wbStb) begin
                if (!inCycle) begin
                    inCycle = 1'b1;
                    waitLeft = $unsigned($random(seed)) % 4;
                    capAdr = wbAdr;
                    capDat = wbDatW;
                    capSel = wbSel;
                    capWe = wbWe;
                end else begin
                    checkWord("wbAdr", wbAdr, capAdr);
                    checkSel("wbSel", wbSel, capSel);
                    checkWord("wbWe", {31'b0, wbWe}, {31'b0, capWe});
                    if (capWe) begin
                        checkWord("wbDatW", wbDatW, capDat);
                    end
                end
                if (waitLeft == 0) begin
                    wbAck = 1'b1;
                    wbDatR = dmem[capAdr[9:2]];
                    if (capWe) begin
                        matchStore();
                        for (int i = 0; i < selW; i++) begin
                            if (capSel[i]) begin
                                dmem[capAdr[9:2]][8*i +: 8] = capDat[8*i +: 8];
                            end
                        end
                    end
                end else begin
                    waitLeft = waitLeft - 1;
                end
            end else if (inCycle) begin
                abortRun("cycle or strobe dropped before ack");
            end
        end
    end

    initial begin
        integer cycles;
        clk = 1'b0;
        rstN = 1'b0;
        wbDatR = '0;
        wbAck = 1'b0;
        inCycle = 1'b0;
        waitLeft = 0;
        seed = 82685;
        expPc = '0;
        for (int i = 0; i < memWords; i++) begin
            imem[i] = {i[24:0], 7'b0001011};
            dmem[i] = {i[15:0], ~i[15:0]};
        end
        loadTests();
        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;

        cycles = 0;
        while (!halted && cycles < haltLimit) begin
            @(posedge clk);
            #3;
            cycles++;
        end
        if (!halted) begin
            abortRun("the core did not halt within the cycle limit");
        end

        // bus must stay quiet and pc frozen after halt
        repeat (10) @(posedge clk);
        #3;
        checkWord("instrAddr", instrAddr, expPc);
        if (expAdrQ.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abortRun($sformatf("%0d expected stores never appeared", expAdrQ.size()));
        end
    end

endmodule

//--- verilog/Alu.sv
`timescale 1ns/100ps

module Alu (
    input  logic [rvPkg::xlen-1:0] a,
    input  logic [rvPkg::xlen-1:0] b,
    input  rvPkg::aluOp_t          aluSel,
    output logic [rvPkg::xlen-1:0] result,
    output logic                   zero,
    output logic                   less,
    output logic                   lessU
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // compare flags for branches, independent of the selected op
    assign less  = $signed(a) < $signed(b);
    assign lessU = a < b;

    always_comb begin
        case (aluSel)
            rvPkg::aluSub:  result = a - b;
            rvPkg::aluSll:  result = a << shamt;
            rvPkg::aluSlt:  result = {{(rvPkg::xlen-1){1'b0}}, less};
            rvPkg::aluSltu: result = {{(rvPkg::xlen-1){1'b0}}, lessU};
            rvPkg::aluXor:  result = a ^ b;
            rvPkg::aluSrl:  result = a >> shamt;
            rvPkg::aluSra:  result = $signed(a) >>> shamt;
            rvPkg::aluOr:   result = a | b;
            rvPkg::aluAnd:  result = a & b;
            default:        result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- verilog/ControlUnit.sv
`timescale 1ns/100ps

module ControlUnit (
    input  logic [rvPkg::xlen-1:0]    instr,
    output rvPkg::immFmt_t            immFmt,
    output logic                      regWe,
    output rvPkg::aSrc_t              aSrc,
    output rvPkg::bSrc_t              bSrc,
    output rvPkg::aluOp_t             aluSel,
    output logic                      memRead,
    output logic                      memWrite,
    output logic [rvPkg::funct3W-1:0] memSize,
    output rvPkg::branchKind_t        branchKind,
    output logic                      halt
);

    logic [6:0] opcode;
    logic [rvPkg::funct3W-1:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // funct3 plus the alternate bit (instr[30]) picks the alu op
    function automatic rvPkg::aluOp_t decodeAlu(input logic [rvPkg::funct3W-1:0] f3,
                                                input logic alt);
        case (f3)
            3'b000:  decodeAlu = alt ? rvPkg::aluSub : rvPkg::aluAdd;
            3'b001:  decodeAlu = rvPkg::aluSll;
            3'b010:  decodeAlu = rvPkg::aluSlt;
            3'b011:  decodeAlu = rvPkg::aluSltu;
            3'b100:  decodeAlu = rvPkg::aluXor;
            3'b101:  decodeAlu = alt ? rvPkg::aluSra : rvPkg::aluSrl;
            3'b110:  decodeAlu = rvPkg::aluOr;
            default: decodeAlu = rvPkg::aluAnd;
        endcase
    endfunction

    function automatic rvPkg::branchKind_t decodeBranch(input logic [rvPkg::funct3W-1:0] f3);
        case (f3)
            3'b000:  decodeBranch = rvPkg::brEq;
            3'b001:  decodeBranch = rvPkg::brNe;
            3'b100:  decodeBranch = rvPkg::brLt;
            3'b101:  decodeBranch = rvPkg::brGe;
            3'b110:  decodeBranch = rvPkg::brLtu;
            3'b111:  decodeBranch = rvPkg::brGeu;
            default: decodeBranch = rvPkg::brNone;
        endcase
    endfunction

    assign memSize = funct3;

    always_comb begin
        immFmt     = rvPkg::immI;
        regWe      = 1'b0;
        aSrc       = rvPkg::aReg;
        bSrc       = rvPkg::bReg;
        aluSel     = rvPkg::aluAdd;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        branchKind = rvPkg::brNone;
        halt       = 1'b0;
        case (opcode)
            rvPkg::opLui: begin
                immFmt = rvPkg::immU;
                regWe  = 1'b1;
                bSrc   = rvPkg::bImm;
            end
            rvPkg::opAuipc: begin
                immFmt = rvPkg::immU;
                regWe  = 1'b1;
                aSrc   = rvPkg::aPc;
                bSrc   = rvPkg::bImm;
            end
            rvPkg::opJal: begin
                immFmt     = rvPkg::immJ;
                regWe      = 1'b1;
                aSrc       = rvPkg::aPc;
                bSrc       = rvPkg::bFour;
                branchKind = rvPkg::brJal;
            end
            rvPkg::opJalr: begin
                regWe      = 1'b1;
                aSrc       = rvPkg::aPc;
                bSrc       = rvPkg::bFour;
                branchKind = rvPkg::brJalr;
            end
            rvPkg::opBranch: begin
                // subtract so the zero flag means rs1 == rs2
                immFmt     = rvPkg::immB;
                aluSel     = rvPkg::aluSub;
                branchKind = decodeBranch(funct3);
            end
            rvPkg::opLoad: begin
                regWe   = 1'b1;
                bSrc    = rvPkg::bImm;
                memRead = 1'b1;
            end
            rvPkg::opStore: begin
                immFmt   = rvPkg::immS;
                bSrc     = rvPkg::bImm;
                memWrite = 1'b1;
            end
            rvPkg::opImm: begin
                // bit 30 only matters for srai
                regWe  = 1'b1;
                bSrc   = rvPkg::bImm;
                aluSel = decodeAlu(funct3, (funct3 == 3'b101) && instr[30]);
            end
            rvPkg::opReg: begin
                regWe  = 1'b1;
                aluSel = decodeAlu(funct3, instr[30]);
            end
            rvPkg::opSystem: begin
                // ecall only when everything above the opcode is zero
                halt = (instr[rvPkg::xlen-1:7] == '0);
            end
            default: begin
            end
        endcase
    end

endmodule

//--- verilog/ImmGen.sv
`timescale 1ns/100ps

module ImmGen (
    input  logic [rvPkg::xlen-1:0] instr,
    input  rvPkg::immFmt_t         immFmt,
    output logic [rvPkg::xlen-1:0] imm
);

    localparam int xlen = rvPkg::xlen;

    always_comb begin
        case (immFmt)
            rvPkg::immS: imm = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
            rvPkg::immB: imm = {{(xlen-13){instr[31]}}, instr[31], instr[7],
                                instr[30:25], instr[11:8], 1'b0};
            rvPkg::immU: imm = {instr[31:12], 12'b0};
            // jal offset, bits scattered across the upper word
            rvPkg::immJ: imm = {{(xlen-21){instr[31]}}, instr[31], instr[19:12],
                                instr[20], instr[30:21], 1'b0};
            default:     imm = {{(xlen-12){instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

//--- verilog/LoadStoreUnit.sv
`timescale 1ns/100ps

module LoadStoreUnit (
    input  logic                      memRead,
    input  logic                      memWrite,
    input  logic [rvPkg::funct3W-1:0] memSize,
    input  logic [rvPkg::xlen-1:0]    addr,
    input  logic [rvPkg::xlen-1:0]    storeData,
    output logic [rvPkg::xlen-1:0]    loadData,
    output logic                      busy,
    output logic                      wbCyc,
    output logic                      wbStb,
    output logic                      wbWe,
    output logic [rvPkg::xlen-1:0]    wbAdr,
    output logic [rvPkg::xlen-1:0]    wbDatW,
    output logic [rvPkg::selW-1:0]    wbSel,
    input  logic [rvPkg::xlen-1:0]    wbDatR,
    input  logic                      wbAck
);

    logic req;
    logic [1:0] offset;
    logic [rvPkg::xlen-1:0] laneData;

    assign req    = memRead || memWrite;
    assign offset = addr[1:0];

    // classic cycle held open by the decoded instruction until ack
    assign wbCyc = req;
    assign wbStb = req;
    assign wbWe  = memWrite;
    assign wbAdr = {addr[rvPkg::xlen-1:2], 2'b00};
    assign busy  = req && !wbAck;

    // addressed lane moved down to bit 0
    assign laneData = wbDatR >> {offset, 3'b000};

    always_comb begin
        case (memSize[1:0])
            2'b00: begin
                wbSel    = 4'b0001 << offset;
                wbDatW   = {4{storeData[7:0]}};
                loadData = memSize[2] ? {24'b0, laneData[7:0]}
                                      : {{24{laneData[7]}}, laneData[7:0]};
            end
            2'b01: begin
                wbSel    = 4'b0011 << {offset[1], 1'b0};
                wbDatW   = {2{storeData[15:0]}};
                loadData = memSize[2] ? {16'b0, laneData[15:0]}
                                      : {{16{laneData[15]}}, laneData[15:0]};
            end
            default: begin
                wbSel    = 4'b1111;
                wbDatW   = storeData;
                loadData = wbDatR;
            end
        endcase
    end

endmodule

//--- verilog/ProgramCounter.sv
`timescale 1ns/100ps

module ProgramCounter (
    input  logic                   clk,
    input  logic                   rstN,
    input  rvPkg::branchKind_t     branchKind,
    input  logic                   zero,
    input  logic                   less,
    input  logic                   lessU,
    input  logic                   busy,
    input  logic                   halt,
    input  logic [rvPkg::xlen-1:0] imm,
    input  logic [rvPkg::xlen-1:0] rs1Data,
    output logic [rvPkg::xlen-1:0] pc,
    output logic [rvPkg::xlen-1:0] pcPlus4,
    output logic                   halted
);

    logic taken;
    logic [rvPkg::xlen-1:0] target;
    logic [rvPkg::xlen-1:0] nextPc;

    always_comb begin
        case (branchKind)
            rvPkg::brJal,
            rvPkg::brJalr: taken = 1'b1;
            rvPkg::brEq:   taken = zero;
            rvPkg::brNe:   taken = !zero;
            rvPkg::brLt:   taken = less;
            rvPkg::brGe:   taken = !less;
            rvPkg::brLtu:  taken = lessU;
            rvPkg::brGeu:  taken = !lessU;
            default:       taken = 1'b0;
        endcase
    end

    // jalr target drops bit 0
    assign target  = (branchKind == rvPkg::brJalr) ? ((rs1Data + imm) & ~32'd1) : (pc + imm);
    assign pcPlus4 = pc + 32'd4;
    assign nextPc  = taken ? target : pcPlus4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= rvPkg::resetVector;
            halted <= 1'b0;
        end else begin
            if (halt && !busy) begin
                halted <= 1'b1;
            end
            if (!busy && !halt && !halted) begin
                pc <= nextPc;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

endmodule

//--- verilog/RegFile.sv
`timescale 1ns/100ps

module RegFile (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [rvPkg::regAddrW-1:0] rs1,
    input  logic [rvPkg::regAddrW-1:0] rs2,
    input  logic [rvPkg::regAddrW-1:0] rd,
    input  logic [rvPkg::xlen-1:0]     wdata,
    input  logic                       we,
    output logic [rvPkg::xlen-1:0]     rdata1,
    output logic [rvPkg::xlen-1:0]     rdata2
);

    localparam int depth = 2 ** rvPkg::regAddrW;

    logic [rvPkg::xlen-1:0] regs [depth];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    // a live register is never loaded with unknown data
    assert property (@(posedge clk) disable iff (!rstN)
        (we && (rd != '0)) |-> !$isunknown(wdata))
        else $error("register x%0d written with unknown data", rd);

endmodule

//--- verilog/RvCore.sv
`timescale 1ns/100ps

module RvCore (
    input  logic                   clk,
    input  logic                   rstN,
    output logic [rvPkg::xlen-1:0] instrAddr,
    input  logic [rvPkg::xlen-1:0] instrData,
    output logic                   wbCyc,
    output logic                   wbStb,
    output logic                   wbWe,
    output logic [rvPkg::xlen-1:0] wbAdr,
    output logic [rvPkg::xlen-1:0] wbDatW,
    output logic [rvPkg::selW-1:0] wbSel,
    input  logic [rvPkg::xlen-1:0] wbDatR,
    input  logic                   wbAck,
    output logic                   halted
);

    rvPkg::immFmt_t immFmt;
    rvPkg::aSrc_t aSrc;
    rvPkg::bSrc_t bSrc;
    rvPkg::aluOp_t aluSel;
    rvPkg::branchKind_t branchKind;
    logic regWe;
    logic memRead;
    logic memWrite;
    logic [rvPkg::funct3W-1:0] memSize;
    logic halt;
    logic running;
    logic lsuBusy;
    logic isJump;
    logic zero;
    logic less;
    logic lessU;
    logic [rvPkg::regAddrW-1:0] rs1Addr;
    logic [rvPkg::xlen-1:0] imm;
    logic [rvPkg::xlen-1:0] rs1Data;
    logic [rvPkg::xlen-1:0] rs2Data;
    logic [rvPkg::xlen-1:0] aluA;
    logic [rvPkg::xlen-1:0] aluB;
    logic [rvPkg::xlen-1:0] aluResult;
    logic [rvPkg::xlen-1:0] pc;
    logic [rvPkg::xlen-1:0] pcPlus4;
    logic [rvPkg::xlen-1:0] loadData;
    logic [rvPkg::xlen-1:0] wbData;

    // first fetch waits one cycle after reset so no bus cycle starts during it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign instrAddr = pc;

    ControlUnit uControl (
        .instr(instrData), .immFmt(immFmt), .regWe(regWe), .aSrc(aSrc), .bSrc(bSrc),
        .aluSel(aluSel), .memRead(memRead), .memWrite(memWrite), .memSize(memSize),
        .branchKind(branchKind), .halt(halt)
    );

    ImmGen uImm (.instr(instrData), .immFmt(immFmt), .imm(imm));

    // lui reads x0 so the alu passes the immediate through
    assign rs1Addr = (instrData[6:0] == rvPkg::opLui) ? '0 : instrData[19:15];

    RegFile uRegs (
        .clk(clk), .rstN(rstN), .rs1(rs1Addr), .rs2(instrData[24:20]),
        .rd(instrData[11:7]), .wdata(wbData), .we(regWe && running && !lsuBusy && !halted),
        .rdata1(rs1Data), .rdata2(rs2Data)
    );

    assign aluA = (aSrc == rvPkg::aPc) ? pc : rs1Data;

    always_comb begin
        case (bSrc)
            rvPkg::bImm:  aluB = imm;
            rvPkg::bFour: aluB = 32'd4;
            default:      aluB = rs2Data;
        endcase
    end

    Alu uAlu (
        .a(aluA), .b(aluB), .aluSel(aluSel), .result(aluResult),
        .zero(zero), .less(less), .lessU(lessU)
    );

    ProgramCounter uPc (
        .clk(clk), .rstN(rstN), .branchKind(branchKind), .zero(zero), .less(less),
        .lessU(lessU), .busy(lsuBusy || !running), .halt(halt), .imm(imm),
        .rs1Data(rs1Data), .pc(pc), .pcPlus4(pcPlus4), .halted(halted)
    );

    LoadStoreUnit uLsu (
        .memRead(memRead && running && !halted), .memWrite(memWrite && running && !halted),
        .memSize(memSize), .addr(aluResult), .storeData(rs2Data), .loadData(loadData),
        .busy(lsuBusy), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbSel(wbSel), .wbDatR(wbDatR), .wbAck(wbAck)
    );

    // writeback select
    assign isJump = (branchKind == rvPkg::brJal) || (branchKind == rvPkg::brJalr);
    assign wbData = memRead ? loadData : (isJump ? pcPlus4 : aluResult);

endmodule

//--- verilog/rvPkg.sv
package rvPkg;

    // datapath widths
    localparam int xlen = 32;
    localparam int regAddrW = 5;
    localparam int funct3W = 3;
    localparam int selW = xlen / 8;

    // first fetch after reset
    localparam logic [xlen-1:0] resetVector = '0;

    // major opcodes, instr[6:0]
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opSystem = 7'b1110011;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd
    } aluOp_t;

    typedef enum logic [2:0] {
        immI, immS, immB, immU, immJ
    } immFmt_t;

    // how the next pc is chosen
    typedef enum logic [3:0] {
        brNone, brJal, brJalr, brEq, brNe, brLt, brGe, brLtu, brGeu
    } branchKind_t;

    typedef enum logic {
        aReg, aPc
    } aSrc_t;

    typedef enum logic [1:0] {
        bReg, bImm, bFour
    } bSrc_t;

endpackage
